/* run_sim.sh */
#!/bin/sh
# Build and run the NIC host testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module nic_host_tb -f sim.f -o nic_host_sim

status=0
./obj_dir/nic_host_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "TB FAILED" sim.log || ! grep -q "TB PASSED" sim.log; then
	echo "Simulation failed, see sim.log"
	exit 1
fi
echo "Simulation passed"

/* sim.f */
verilog/nic_pkg.sv
verilog/mem_bus_if.sv
verilog/nic_reset_ctrl.sv
verilog/nic_axil_target.sv
verilog/nic_tx_fetch.sv
verilog/nic_mem_arbiter.sv
verilog/nic_host_top.sv
tests/nic_host_checker.sv
tests/nic_host_assert.sv
tests/nic_host_tb.sv

/* tests/nic_host_assert.sv */
module nic_host_assert import nic_pkg::*; (
	input logic aclk,
	input logic rstni,
	input logic [1:0] bresp_i,
	input logic bvalid_i,
	input logic bready_i,
	input data_t rdata_i,
	input logic [1:0] rresp_i,
	input logic rvalid_i,
	input logic rready_i,
	input logic irq_i
);

	b_hold: assert property (@(posedge aclk) disable iff (!rstni)
		(bvalid_i && !bready_i) |=> (bvalid_i && $stable(bresp_i)))
		else $error("bvalid or bresp changed before bready");

	// Read data must hold along with the response
	r_hold: assert property (@(posedge aclk) disable iff (!rstni)
		(rvalid_i && !rready_i) |=> (rvalid_i && $stable(rresp_i) && $stable(rdata_i)))
		else $error("rvalid, rresp or rdata changed before rready");

	irq_in_reset: assert property (@(posedge aclk) !rstni |-> !irq_i)
		else $error("irq_o high while reset is asserted");

endmodule

bind nic_host_top nic_host_assert assert0 (
	.aclk(aclk),
	.rstni(rstni),
	.bresp_i(s_bresp_o),
	.bvalid_i(s_bvalid_o),
	.bready_i(s_bready_i),
	.rdata_i(s_rdata_o),
	.rresp_i(s_rresp_o),
	.rvalid_i(s_rvalid_o),
	.rready_i(s_rready_i),
	.irq_i(irq_o)
);

/* tests/nic_host_checker.sv */
module nic_host_checker import nic_pkg::*; (
	input logic aclk,
	input logic [1:0] bresp_i,
	input logic bvalid_i,
	input logic bready_i,
	input data_t rdata_i,
	input logic [1:0] rresp_i,
	input logic rvalid_i,
	input logic rready_i,
	input logic irq_i,
	output int errors_o,
	output int checks_o
);

	string rd_name_q[$];
	data_t rd_data_q[$];
	logic [1:0] rd_resp_q[$];
	string wr_name_q[$];
	logic [1:0] wr_resp_q[$];

	int errors = 0;
	int checks = 0;
	logic irq_low_on = 1'b0;
	logic irq_flagged = 1'b0;
	string irq_name;
	string name;
	data_t exp_data;
	logic [1:0] exp_resp;

	task automatic expect_read(input string tname, input data_t data, input logic [1:0] resp);
		rd_name_q.push_back(tname);
		rd_data_q.push_back(data);
		rd_resp_q.push_back(resp);
	endtask

	task automatic expect_write(input string tname, input logic [1:0] resp);
		wr_name_q.push_back(tname);
		wr_resp_q.push_back(resp);
	endtask

	// While armed, any high irq_o is an error
	task automatic watch_irq_low(input string tname, input logic on);
		irq_name = tname;
		irq_low_on = on;
		irq_flagged = 1'b0;
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		errors++;
	endtask

	always @(posedge aclk) begin
		if (bvalid_i && bready_i) begin
			if (wr_name_q.size() == 0) begin
				report_failure("Write response seen with no write outstanding");
			end else begin
				name = wr_name_q.pop_front();
				exp_resp = wr_resp_q.pop_front();
				checks++;
				if (bresp_i !== exp_resp) begin
					$display("** Error [%s] bresp expected %0h actual %0h", name, exp_resp, bresp_i);
					errors++;
				end
			end
		end
		if (rvalid_i && rready_i) begin
			if (rd_name_q.size() == 0) begin
				report_failure("Read data seen with no read outstanding");
			end else begin
				name = rd_name_q.pop_front();
				exp_data = rd_data_q.pop_front();
				exp_resp = rd_resp_q.pop_front();
				checks++;
				if (rdata_i !== exp_data) begin
					$display("** Error [%s] rdata expected %08h actual %08h", name, exp_data, rdata_i);
					errors++;
				end
				if (rresp_i !== exp_resp) begin
					$display("** Error [%s] rresp expected %0h actual %0h", name, exp_resp, rresp_i);
					errors++;
				end
			end
		end
		if (irq_low_on && irq_i && !irq_flagged) begin
			$display("** Error [%s] irq_o expected 0 actual 1", irq_name);
			irq_flagged = 1'b1;
			errors++;
		end
	end

	assign errors_o = errors;
	assign checks_o = checks;

endmodule

/* tests/nic_host_stim.txt */
# op name addr data expect (hex). W: expect is bresp. R: data is rresp, expect is rdata.
# I: addr is a cycle count, expect 1 waits for irq_o high, expect 0 needs it low throughout.
R status_rst 0008 0 00000000
R txbytes_rst 0040 0 00000000
W ims_wr 00D0 FFFFFFFF 0
R ims_rd 00D0 0 00000001
W ims_clr 00D0 00000000 0
W tdt_wr 3818 FFFFFFF3 0
R tdt_rd 3818 0 00000003
W tdt_zero 3818 00000000 0
R unmapped_rd 0100 2 00000000
W unmapped_wr 0104 12345678 2
W desc0 8000 01000040 0
W desc1 8004 020005EA 0
W desc2 8008 03000100 0
W desc3 800C 0400003C 0
W win_a 8100 DEADBEEF 0
W win_b 8FFC 5A5AA5A5 0
W tdt_four 3818 00000004 0
W tx_enable 0000 00000001 0
R win_a_busy 8100 0 DEADBEEF
R win_b_busy 8FFC 0 5A5AA5A5
I irq_masked 0064 0 0
R tdh_done 3810 0 00000004
R txbytes_sum 0040 0 00000766
R status_idle 0008 0 00000000
R desc0_dd 8000 0 81000040
R desc1_dd 8004 0 820005EA
R desc2_dd 8008 0 83000100
R desc3_dd 800C 0 8400003C
W ims_set 00D0 00000001 0
I irq_rise 0014 0 1
R ctrl_rd 0000 0 00000001
R icr_rd 00C0 0 00000001
I irq_fall 0020 0 0
R icr_clr 00C0 0 00000000
W sw_reset 0000 04000000 0
R tdh_swrst 3810 0 00000000
R tdt_swrst 3818 0 00000000
R txbytes_swrst 0040 0 00000000
R ims_swrst 00D0 0 00000000
R ctrl_swrst 0000 0 00000000
R desc0_keep 8000 0 81000040
R desc3_keep 800C 0 8400003C

/* tests/nic_host_tb.sv */
module nic_host_tb import nic_pkg::*; ();

	localparam int RESET_CYCLES = 16;
	localparam string STIM_FILE = "tests/nic_host_stim.txt";

	logic aclk, rstni;
	reg_addr_t awaddr, araddr;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready, irq;
	data_t wdata, rdata;
	logic [3:0] wstrb;
	logic [1:0] bresp, rresp;
	int errors, checks;
	int cycle_cnt = 0;
	int cycle_limit = 0;

	string op_q[$];
	string name_q[$];
	data_t addr_q[$];
	data_t data_q[$];
	data_t exp_q[$];

	nic_host_top #(.MEM_AW(10), .RING_SIZE(16), .RESET_CYCLES(RESET_CYCLES)) dut0 (
		.aclk(aclk),
		.rstni(rstni),
		.s_awaddr_i(awaddr),
		.s_awvalid_i(awvalid),
		.s_awready_o(awready),
		.s_wdata_i(wdata),
		.s_wstrb_i(wstrb),
		.s_wvalid_i(wvalid),
		.s_wready_o(wready),
		.s_bresp_o(bresp),
		.s_bvalid_o(bvalid),
		.s_bready_i(bready),
		.s_araddr_i(araddr),
		.s_arvalid_i(arvalid),
		.s_arready_o(arready),
		.s_rdata_o(rdata),
		.s_rresp_o(rresp),
		.s_rvalid_o(rvalid),
		.s_rready_i(rready),
		.irq_o(irq)
	);

	nic_host_checker chk0 (
		.aclk(aclk),
		.bresp_i(bresp),
		.bvalid_i(bvalid),
		.bready_i(bready),
		.rdata_i(rdata),
		.rresp_i(rresp),
		.rvalid_i(rvalid),
		.rready_i(rready),
		.irq_i(irq),
		.errors_o(errors),
		.checks_o(checks)
	);

	initial begin
		aclk = 1'b0;
		forever #20 aclk = ~aclk;
	end

	always @(posedge aclk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("Run stopped: still busy after %0d cycles", cycle_cnt);
			$display("TB FAILED");
			$finish;
		end
	end

	task automatic load_stim();
		int fd;
		string line, op, name;
		data_t a, d, e;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			return;
		end
		while (!$feof(fd)) begin
			if ($fgets(line, fd) == 0) begin
				break;
			end
			if (line.len() < 2 || line.substr(0, 0) == "#") begin
				continue;
			end
			if ($sscanf(line, "%s %s %h %h %h", op, name, a, d, e) == 5) begin
				op_q.push_back(op);
				name_q.push_back(name);
				addr_q.push_back(a);
				data_q.push_back(d);
				exp_q.push_back(e);
			end
		end
		$fclose(fd);
	endtask

	// Write with a random bready stall once bvalid is up
	task automatic axi_write(input reg_addr_t addr, input data_t data);
		int stall;
		stall = int'($urandom % 4);
		awaddr <= addr;
		awvalid <= 1'b1;
		wdata <= data;
		wstrb <= 4'hF;
		wvalid <= 1'b1;
		bready <= 1'b0;
		do begin
			@(posedge aclk);
		end while (!(awready && wready));
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		do begin
			@(posedge aclk);
		end while (!bvalid);
		repeat (stall) @(posedge aclk);
		bready <= 1'b1;
		do begin
			@(posedge aclk);
		end while (!(bvalid && bready));
		bready <= 1'b0;
	endtask

	// Read with a random rready stall once rvalid is up
	task automatic axi_read(input reg_addr_t addr);
		int stall;
		stall = int'($urandom % 4);
		araddr <= addr;
		arvalid <= 1'b1;
		rready <= 1'b0;
		do begin
			@(posedge aclk);
		end while (!arready);
		arvalid <= 1'b0;
		do begin
			@(posedge aclk);
		end while (!rvalid);
		repeat (stall) @(posedge aclk);
		rready <= 1'b1;
		do begin
			@(posedge aclk);
		end while (!(rvalid && rready));
		rready <= 1'b0;
	endtask

	task automatic check_irq(input string name, input int cycles, input logic level);
		int waited;
		waited = 0;
		if (level) begin
			while (!irq && waited < cycles) begin
				@(posedge aclk);
				waited++;
			end
			if (!irq) begin
				chk0.report_failure($sformatf("Test %s: irq_o did not rise within %0d cycles",
					name, cycles));
			end
		end else begin
			chk0.watch_irq_low(name, 1'b1);
			repeat (cycles) @(posedge aclk);
			chk0.watch_irq_low(name, 1'b0);
		end
	endtask

	task automatic run_ops();
		data_t a, d, e;
		for (int i = 0; i < op_q.size(); i++) begin
			a = addr_q[i];
			d = data_q[i];
			e = exp_q[i];
			case (op_q[i])
				"W": begin
					chk0.expect_write(name_q[i], e[1:0]);
					axi_write(a[15:0], d);
					// Software reset, wait for the core to come back
					if (a[15:0] == REG_CTRL && d[CTRL_RST_BIT]) begin
						repeat (RESET_CYCLES + 4) @(posedge aclk);
					end
				end
				"R": begin
					chk0.expect_read(name_q[i], e, d[1:0]);
					axi_read(a[15:0]);
				end
				"I": check_irq(name_q[i], int'(a), e[0]);
				default: chk0.report_failure($sformatf("Unknown operation %s in test %s",
					op_q[i], name_q[i]));
			endcase
		end
	endtask

	initial begin
		rstni <= 1'b0;
		awaddr <= '0;
		awvalid <= 1'b0;
		wdata <= '0;
		wstrb <= '0;
		wvalid <= 1'b0;
		bready <= 1'b0;
		araddr <= '0;
		arvalid <= 1'b0;
		rready <= 1'b0;
		void'($urandom(32'hca91));
		load_stim();
		if (op_q.size() == 0) begin
			$display("Stimulus file %s missing or empty", STIM_FILE);
			$display("TB FAILED");
		end else begin
			cycle_limit = op_q.size() * 200;
			repeat (8) @(posedge aclk);
			rstni <= 1'b1;
			repeat (RESET_CYCLES + 4) @(posedge aclk);
			run_ops();
			repeat (4) @(posedge aclk);
			$display("Checks run: %0d, errors: %0d", checks, errors);
			if (errors == 0) begin
				$display("TB PASSED");
			end else begin
				$display("TB FAILED");
			end
		end
		$finish;
	end

endmodule

/* verilog/mem_bus_if.sv */
interface mem_bus_if import nic_pkg::*; #(
	parameter int MEM_AW = 10
);

	// Request side, held by the master until gnt
	logic req;
	logic we;
	logic [MEM_AW-1:0] addr;
	data_t wdata;

	// Response side
	logic gnt;
	data_t rdata;
	logic rvalid;

	modport master (
		output req,
		output we,
		output addr,
		output wdata,
		input gnt,
		input rdata,
		input rvalid
	);

	modport slave (
		input req,
		input we,
		input addr,
		input wdata,
		output gnt,
		output rdata,
		output rvalid
	);

endinterface

/* verilog/nic_axil_target.sv */
module nic_axil_target import nic_pkg::*; #(
	parameter int MEM_AW = 10,
	parameter int RING_SIZE = 16,
	localparam int RING_W = $clog2(RING_SIZE)
) (
	input logic aclk,
	input logic rstni,
	input logic core_rstn_i,

	input reg_addr_t s_awaddr_i,
	input logic s_awvalid_i,
	output logic s_awready_o,
	input data_t s_wdata_i,
	input logic [3:0] s_wstrb_i,
	input logic s_wvalid_i,
	output logic s_wready_o,
	output logic [1:0] s_bresp_o,
	output logic s_bvalid_o,
	input logic s_bready_i,
	input reg_addr_t s_araddr_i,
	input logic s_arvalid_i,
	output logic s_arready_o,
	output data_t s_rdata_o,
	output logic [1:0] s_rresp_o,
	output logic s_rvalid_o,
	input logic s_rready_i,

	mem_bus_if.master host_mem,

	output logic sw_reset_o,
	output logic tx_enable_o,
	output logic [RING_W-1:0] tdt_o,
	input logic [RING_W-1:0] tdh_i,
	input data_t tx_bytes_i,
	input logic busy_i,
	input logic txdw_set_i,
	output logic irq_o
);

	tgt_state_e state_q;
	logic bvalid_q, rvalid_q, mem_req_q, sw_reset_q;
	logic mem_we_q;
	logic [MEM_AW-1:0] mem_addr_q;
	data_t mem_wdata_q, rdata_q;
	logic [1:0] bresp_q, rresp_q;

	logic tx_enable_q, ims_q, icr_q;
	logic [RING_W-1:0] tdt_q;

	logic wr_accept, rd_accept, aw_win, ar_win, aw_hit, ar_hit;
	logic reg_wr, icr_rd;
	data_t aw_old, ar_val, wr_val;

	function automatic logic in_window(input reg_addr_t a);
		return a[15] && (int'(a[14:2]) < (1 << MEM_AW));
	endfunction

	// Current register value, returns 0 for an unmapped offset
	function automatic logic reg_lookup(input reg_addr_t a, output data_t d);
		d = '0;
		case (a)
			REG_CTRL: d[CTRL_TXEN_BIT] = tx_enable_q;
			REG_STATUS: d[0] = busy_i;
			REG_ICR: d[0] = icr_q;
			REG_IMS: d[0] = ims_q;
			REG_TXBYTES: d = tx_bytes_i;
			REG_TDH: d = data_t'(tdh_i);
			REG_TDT: d = data_t'(tdt_q);
			default: return 1'b0;
		endcase
		return 1'b1;
	endfunction

	// One transaction at a time, write wins when both arrive
	assign wr_accept = (state_q == TS_IDLE) && s_awvalid_i && s_wvalid_i;
	assign rd_accept = (state_q == TS_IDLE) && s_arvalid_i && !(s_awvalid_i && s_wvalid_i);
	assign s_awready_o = wr_accept;
	assign s_wready_o = wr_accept;
	assign s_arready_o = rd_accept;

	always_comb begin
		aw_win = in_window(s_awaddr_i);
		ar_win = in_window(s_araddr_i);
		aw_hit = reg_lookup(s_awaddr_i, aw_old);
		ar_hit = reg_lookup(s_araddr_i, ar_val);
		for (int i = 0; i < 4; i++) begin
			wr_val[8*i +: 8] = s_wstrb_i[i] ? s_wdata_i[8*i +: 8] : aw_old[8*i +: 8];
		end
	end

	assign reg_wr = wr_accept && !aw_win && aw_hit;
	assign icr_rd = rd_accept && !ar_win && (s_araddr_i == REG_ICR);

	always_ff @(posedge aclk or negedge rstni) begin
		if (!rstni) begin
			state_q <= TS_IDLE;
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
			mem_req_q <= 1'b0;
			sw_reset_q <= 1'b0;
		end else begin
			sw_reset_q <= reg_wr && (s_awaddr_i == REG_CTRL) && wr_val[CTRL_RST_BIT];
			case (state_q)
				TS_IDLE: begin
					if (wr_accept) begin
						mem_req_q <= aw_win;
						bvalid_q <= !aw_win;
						state_q <= aw_win ? TS_MEM_WAIT : TS_RESP;
					end else if (rd_accept) begin
						mem_req_q <= ar_win;
						rvalid_q <= !ar_win;
						state_q <= ar_win ? TS_MEM_WAIT : TS_RESP;
					end
				end
				TS_MEM_WAIT: begin
					if (mem_req_q) begin
						if (host_mem.gnt) begin
							mem_req_q <= 1'b0;
							if (mem_we_q) begin
								bvalid_q <= 1'b1;
								state_q <= TS_RESP;
							end
						end
					end else if (host_mem.rvalid) begin
						rvalid_q <= 1'b1;
						state_q <= TS_RESP;
					end
				end
				TS_RESP: begin
					if ((bvalid_q && s_bready_i) || (rvalid_q && s_rready_i)) begin
						bvalid_q <= 1'b0;
						rvalid_q <= 1'b0;
						state_q <= TS_IDLE;
					end
				end
				default: state_q <= TS_IDLE;
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (wr_accept) begin
			mem_we_q <= 1'b1;
			mem_addr_q <= s_awaddr_i[MEM_AW+1:2];
			mem_wdata_q <= s_wdata_i;
			bresp_q <= (aw_win || aw_hit) ? RESP_OKAY : RESP_SLVERR;
		end else if (rd_accept) begin
			mem_we_q <= 1'b0;
			mem_addr_q <= s_araddr_i[MEM_AW+1:2];
			rdata_q <= ar_val;
			rresp_q <= (ar_win || ar_hit) ? RESP_OKAY : RESP_SLVERR;
		end else if (state_q == TS_MEM_WAIT && !mem_req_q && host_mem.rvalid) begin
			rdata_q <= host_mem.rdata;
		end
	end

	// Register bank, cleared by the core reset
	always_ff @(posedge aclk or negedge core_rstn_i) begin
		if (!core_rstn_i) begin
			tx_enable_q <= 1'b0;
			ims_q <= 1'b0;
			icr_q <= 1'b0;
			tdt_q <= '0;
		end else begin
			if (reg_wr && s_awaddr_i == REG_CTRL) begin
				tx_enable_q <= wr_val[CTRL_TXEN_BIT];
			end
			if (reg_wr && s_awaddr_i == REG_IMS) begin
				ims_q <= wr_val[0];
			end
			if (reg_wr && s_awaddr_i == REG_TDT) begin
				tdt_q <= wr_val[RING_W-1:0];
			end
			// A cause arriving with the clearing read is kept
			icr_q <= (icr_q && !icr_rd) || txdw_set_i;
		end
	end

	assign host_mem.req = mem_req_q;
	assign host_mem.we = mem_we_q;
	assign host_mem.addr = mem_addr_q;
	assign host_mem.wdata = mem_wdata_q;

	assign s_bvalid_o = bvalid_q;
	assign s_bresp_o = bresp_q;
	assign s_rvalid_o = rvalid_q;
	assign s_rdata_o = rdata_q;
	assign s_rresp_o = rresp_q;

	assign sw_reset_o = sw_reset_q;
	assign tx_enable_o = tx_enable_q;
	assign tdt_o = tdt_q;
	assign irq_o = icr_q && ims_q;

endmodule

/* verilog/nic_host_top.sv */
module nic_host_top import nic_pkg::*; #(
	parameter int MEM_AW = 10,
	parameter int RING_SIZE = 16,
	parameter int RESET_CYCLES = 16
) (
	input logic aclk,
	input logic rstni,

	input reg_addr_t s_awaddr_i,
	input logic s_awvalid_i,
	output logic s_awready_o,
	input data_t s_wdata_i,
	input logic [3:0] s_wstrb_i,
	input logic s_wvalid_i,
	output logic s_wready_o,
	output logic [1:0] s_bresp_o,
	output logic s_bvalid_o,
	input logic s_bready_i,
	input reg_addr_t s_araddr_i,
	input logic s_arvalid_i,
	output logic s_arready_o,
	output data_t s_rdata_o,
	output logic [1:0] s_rresp_o,
	output logic s_rvalid_o,
	input logic s_rready_i,

	output logic irq_o
);

	localparam int RING_W = $clog2(RING_SIZE);

	logic sw_reset, core_rstn, tx_enable, busy, txdw_set;
	logic [RING_W-1:0] tdt, tdh;
	data_t tx_bytes;

	mem_bus_if #(.MEM_AW(MEM_AW)) host_mem ();
	mem_bus_if #(.MEM_AW(MEM_AW)) fetch_mem ();

	nic_reset_ctrl #(.RESET_CYCLES(RESET_CYCLES)) reset_ctrl_i (
		.aclk(aclk),
		.rstni(rstni),
		.sw_reset_i(sw_reset),
		.core_rstn_o(core_rstn)
	);

	nic_axil_target #(.MEM_AW(MEM_AW), .RING_SIZE(RING_SIZE)) target_i (
		.aclk(aclk),
		.rstni(rstni),
		.core_rstn_i(core_rstn),
		.s_awaddr_i(s_awaddr_i),
		.s_awvalid_i(s_awvalid_i),
		.s_awready_o(s_awready_o),
		.s_wdata_i(s_wdata_i),
		.s_wstrb_i(s_wstrb_i),
		.s_wvalid_i(s_wvalid_i),
		.s_wready_o(s_wready_o),
		.s_bresp_o(s_bresp_o),
		.s_bvalid_o(s_bvalid_o),
		.s_bready_i(s_bready_i),
		.s_araddr_i(s_araddr_i),
		.s_arvalid_i(s_arvalid_i),
		.s_arready_o(s_arready_o),
		.s_rdata_o(s_rdata_o),
		.s_rresp_o(s_rresp_o),
		.s_rvalid_o(s_rvalid_o),
		.s_rready_i(s_rready_i),
		.host_mem(host_mem.master),
		.sw_reset_o(sw_reset),
		.tx_enable_o(tx_enable),
		.tdt_o(tdt),
		.tdh_i(tdh),
		.tx_bytes_i(tx_bytes),
		.busy_i(busy),
		.txdw_set_i(txdw_set),
		.irq_o(irq_o)
	);

	nic_tx_fetch #(.RING_SIZE(RING_SIZE)) tx_fetch_i (
		.aclk(aclk),
		.core_rstn_i(core_rstn),
		.tx_enable_i(tx_enable),
		.tdt_i(tdt),
		.fetch_mem(fetch_mem.master),
		.tdh_o(tdh),
		.tx_bytes_o(tx_bytes),
		.busy_o(busy),
		.txdw_set_o(txdw_set)
	);

	nic_mem_arbiter #(.MEM_AW(MEM_AW)) mem_arbiter_i (
		.aclk(aclk),
		.core_rstn_i(core_rstn),
		.host_mem(host_mem.slave),
		.fetch_mem(fetch_mem.slave)
	);

endmodule

/* verilog/nic_mem_arbiter.sv */
module nic_mem_arbiter import nic_pkg::*; #(
	parameter int MEM_AW = 10
) (
	input logic aclk,
	input logic core_rstn_i,
	mem_bus_if.slave host_mem,
	mem_bus_if.slave fetch_mem
);

	data_t ram [2**MEM_AW];
	data_t rdata_q;
	logic last_fetch_q, host_rd_q, fetch_rd_q;
	logic pick_host, pick_fetch;
	logic ram_we;
	logic [MEM_AW-1:0] ram_addr;
	data_t ram_wdata;

	// Engine wins only if the host is idle or won last time
	assign pick_fetch = fetch_mem.req && (!host_mem.req || !last_fetch_q);
	assign pick_host = host_mem.req && !pick_fetch;

	assign host_mem.gnt = pick_host;
	assign fetch_mem.gnt = pick_fetch;

	assign ram_we = pick_fetch ? fetch_mem.we : host_mem.we;
	assign ram_addr = pick_fetch ? fetch_mem.addr : host_mem.addr;
	assign ram_wdata = pick_fetch ? fetch_mem.wdata : host_mem.wdata;

	always_ff @(posedge aclk or negedge core_rstn_i) begin
		if (!core_rstn_i) begin
			last_fetch_q <= 1'b1;
			host_rd_q <= 1'b0;
			fetch_rd_q <= 1'b0;
		end else begin
			if (pick_host || pick_fetch) begin
				last_fetch_q <= pick_fetch;
			end
			host_rd_q <= pick_host && !host_mem.we;
			fetch_rd_q <= pick_fetch && !fetch_mem.we;
		end
	end

	always_ff @(posedge aclk) begin
		if (pick_host || pick_fetch) begin
			if (ram_we) begin
				ram[ram_addr] <= ram_wdata;
			end else begin
				rdata_q <= ram[ram_addr];
			end
		end
	end

	assign host_mem.rdata = rdata_q;
	assign fetch_mem.rdata = rdata_q;
	assign host_mem.rvalid = host_rd_q;
	assign fetch_mem.rvalid = fetch_rd_q;

endmodule

/* verilog/nic_pkg.sv */
package nic_pkg;

	typedef logic [31:0] data_t;
	typedef logic [15:0] reg_addr_t;
	typedef logic [15:0] desc_len_t;

	// Register map, byte offsets on the host port
	localparam reg_addr_t REG_CTRL    = 16'h0000;
	localparam reg_addr_t REG_STATUS  = 16'h0008;
	localparam reg_addr_t REG_TXBYTES = 16'h0040;
	localparam reg_addr_t REG_ICR     = 16'h00C0;
	localparam reg_addr_t REG_IMS     = 16'h00D0;
	localparam reg_addr_t REG_TDH     = 16'h3810;
	localparam reg_addr_t REG_TDT     = 16'h3818;
	localparam reg_addr_t MEM_WINDOW  = 16'h8000;

	// CTRL fields
	localparam int CTRL_TXEN_BIT = 0;
	localparam int CTRL_RST_BIT  = 26;

	// Descriptor done flag, length sits in the low half
	localparam int DESC_DD_BIT = 31;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	typedef enum logic [1:0] {
		FS_IDLE,
		FS_REQ_RD,
		FS_WAIT_RD,
		FS_REQ_WR
	} fetch_state_e;

	typedef enum logic [1:0] {
		TS_IDLE,
		TS_MEM_WAIT,
		TS_RESP
	} tgt_state_e;

endpackage

/* verilog/nic_reset_ctrl.sv */
module nic_reset_ctrl #(
	parameter int RESET_CYCLES = 16
) (
	input logic aclk,
	input logic rstni,
	input logic sw_reset_i,
	output logic core_rstn_o
);

	localparam int CNT_W = $clog2(RESET_CYCLES + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(RESET_CYCLES - 1);

	logic [CNT_W-1:0] cnt_q;
	logic core_rstn_q;

	// Counter restarts on either reset source and saturates
	always_ff @(posedge aclk or negedge rstni) begin
		if (!rstni) begin
			cnt_q <= '0;
			core_rstn_q <= 1'b0;
		end else if (sw_reset_i) begin
			cnt_q <= '0;
			core_rstn_q <= 1'b0;
		end else begin
			if (cnt_q != CNT_LAST) begin
				cnt_q <= cnt_q + 1'b1;
			end
			// Released on the edge after the counter saturates
			core_rstn_q <= (cnt_q == CNT_LAST);
		end
	end

	assign core_rstn_o = core_rstn_q;

endmodule

/* verilog/nic_tx_fetch.sv */
module nic_tx_fetch import nic_pkg::*; #(
	parameter int RING_SIZE = 16,
	localparam int RING_W = $clog2(RING_SIZE)
) (
	input logic aclk,
	input logic core_rstn_i,
	input logic tx_enable_i,
	input logic [RING_W-1:0] tdt_i,
	mem_bus_if.master fetch_mem,
	output logic [RING_W-1:0] tdh_o,
	output data_t tx_bytes_o,
	output logic busy_o,
	output logic txdw_set_o
);

	fetch_state_e state_q;
	logic req_q, we_q, txdw_set_q;
	logic [RING_W-1:0] tdh_q, tdh_next;
	data_t tx_bytes_q, wdata_q;
	desc_len_t desc_len;

	assign desc_len = fetch_mem.rdata[15:0];
	assign tdh_next = (tdh_q == RING_W'(RING_SIZE - 1)) ? '0 : tdh_q + 1'b1;

	always_ff @(posedge aclk or negedge core_rstn_i) begin
		if (!core_rstn_i) begin
			state_q <= FS_IDLE;
			req_q <= 1'b0;
			we_q <= 1'b0;
			txdw_set_q <= 1'b0;
			tdh_q <= '0;
			tx_bytes_q <= '0;
		end else begin
			txdw_set_q <= 1'b0;
			case (state_q)
				FS_IDLE: begin
					if (tx_enable_i && tdh_q != tdt_i) begin
						req_q <= 1'b1;
						we_q <= 1'b0;
						state_q <= FS_REQ_RD;
					end
				end
				FS_REQ_RD: begin
					if (fetch_mem.gnt) begin
						req_q <= 1'b0;
						state_q <= FS_WAIT_RD;
					end
				end
				FS_WAIT_RD: begin
					if (fetch_mem.rvalid) begin
						tx_bytes_q <= tx_bytes_q + data_t'(desc_len);
						req_q <= 1'b1;
						we_q <= 1'b1;
						state_q <= FS_REQ_WR;
					end
				end
				FS_REQ_WR: begin
					if (fetch_mem.gnt) begin
						req_q <= 1'b0;
						tdh_q <= tdh_next;
						// Ring drained up to the tail
						txdw_set_q <= (tdh_next == tdt_i);
						state_q <= FS_IDLE;
					end
				end
				default: state_q <= FS_IDLE;
			endcase
		end
	end

	// Write-back word is the fetched one with the done flag set
	always_ff @(posedge aclk) begin
		if (state_q == FS_WAIT_RD && fetch_mem.rvalid) begin
			wdata_q <= fetch_mem.rdata | (data_t'(1) << DESC_DD_BIT);
		end
	end

	always_comb begin
		fetch_mem.addr = '0;
		fetch_mem.addr[RING_W-1:0] = tdh_q;
	end

	assign fetch_mem.req = req_q;
	assign fetch_mem.we = we_q;
	assign fetch_mem.wdata = wdata_q;

	assign tdh_o = tdh_q;
	assign tx_bytes_o = tx_bytes_q;
	assign busy_o = (state_q != FS_IDLE);
	assign txdw_set_o = txdw_set_q;

endmodule
